//--- verilog/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// Longest instruction, counting the overlapped fetch
`define MAX_CYCLES_PER_INSTR 5

// Work RAM window inside the MMU
`define WRAM_BASE  16'hC000
`define WRAM_DEPTH 256

`define PC_RESET 16'h0000
`define SP_RESET 16'hFFFE

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] byte_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [2:0]             cycle_count_t;  // Machine cycle within an instruction

  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_t;

  typedef enum logic [1:0] {ADDR_PC, ADDR_HL, ADDR_WZ, ADDR_NONE} addr_src_t;

  typedef enum logic [1:0] {
    DATA_BUS_OP_READ,
    DATA_BUS_OP_WRITE,
    DATA_BUS_OP_ALU_ONLY
  } data_bus_op_t;

  typedef enum logic [3:0] {
    REG_A, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L,
    REG_Z_TMP, REG_W_TMP, REG_IR
  } reg_sel_t;

  typedef enum logic {IDU_NONE, IDU_INC} idu_op_t;

  typedef enum logic [3:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_CP, ALU_INC, ALU_DEC, ALU_MOV
  } alu_op_t;

  typedef enum logic [2:0] {
    MISC_NONE, MISC_COND_CHECK, MISC_JP_LOAD, MISC_JR_ADD, MISC_HALT
  } misc_op_t;

  typedef enum logic [2:0] {COND_ALWAYS, COND_NZ, COND_Z, COND_NC, COND_C} cond_t;

  // One machine cycle of an instruction
  typedef struct packed {
    addr_src_t    addr_src;
    data_bus_op_t data_bus_op;
    reg_sel_t     data_bus_reg;  // Read target or write source
    idu_op_t      idu_op;        // Applied to the address source in T4
    alu_op_t      alu_op;
    reg_sel_t     alu_dst;
    reg_sel_t     alu_src;
    misc_op_t     misc_op;
    cond_t        cond;
  } mcycle_t;

  typedef struct packed {
    mcycle_t [`MAX_CYCLES_PER_INSTR-1:0] cycles;
    cycle_count_t                        num_cycles;
  } control_word_t;

  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } flags_t;

  typedef struct packed {
    byte_t  a;
    flags_t flags;
    byte_t  b;
    byte_t  c;
    byte_t  d;
    byte_t  e;
    byte_t  h;
    byte_t  l;
    byte_t  w;
    byte_t  z;
    byte_t  ir;
    addr_t  sp;
    addr_t  pc;
  } cpu_regs_t;

  typedef struct packed {
    addr_t addr;
    byte_t wdata;
    logic  read;
    logic  write;
  } bus_req_t;

endpackage

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu
  import cpu_pkg::*;
(
  input  alu_op_t op,
  input  byte_t   a,
  input  byte_t   b,
  input  flags_t  flags_in,
  output byte_t   result,
  output flags_t  flags_out
);

  logic [8:0] sum;
  logic [8:0] diff;
  logic [4:0] sum_lo;
  logic [4:0] diff_lo;
  byte_t      value;  // Computed value, also used by CP for Z

  assign sum     = {1'b0, a} + {1'b0, b};
  assign diff    = {1'b0, a} - {1'b0, b};
  assign sum_lo  = {1'b0, a[3:0]} + {1'b0, b[3:0]};
  assign diff_lo = {1'b0, a[3:0]} - {1'b0, b[3:0]};

  always_comb begin
    value = a;
    flags_out = flags_in;
    case (op)
      ALU_ADD: begin
        value = sum[7:0];
        flags_out.n = 1'b0;
        flags_out.h = sum_lo[4];
        flags_out.c = sum[8];
      end
      ALU_SUB, ALU_CP: begin
        value = diff[7:0];
        flags_out.n = 1'b1;
        flags_out.h = diff_lo[4];  // Borrow out of the low nibble
        flags_out.c = diff[8];
      end
      ALU_AND: begin
        value = a & b;
        flags_out.n = 1'b0;
        flags_out.h = 1'b1;
        flags_out.c = 1'b0;
      end
      ALU_OR, ALU_XOR: begin
        value = (op == ALU_OR) ? (a | b) : (a ^ b);
        flags_out.n = 1'b0;
        flags_out.h = 1'b0;
        flags_out.c = 1'b0;
      end
      ALU_INC: begin
        value = a + 8'd1;
        flags_out.n = 1'b0;
        flags_out.h = (a[3:0] == 4'hf);
      end
      ALU_DEC: begin
        value = a - 8'd1;
        flags_out.n = 1'b1;
        flags_out.h = (a[3:0] == 4'h0);
      end
      ALU_MOV: value = b;  // Flags untouched
      default: value = a;
    endcase
    if (op != ALU_NOP && op != ALU_MOV)
      flags_out.z = (value == 8'h00);
  end

  assign result = (op == ALU_CP) ? a : value;  // CP leaves A alone

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module instr_decoder
  import cpu_pkg::*;
(
  input  byte_t         opcode,
  output control_word_t control_word
);

  // Opcode fetch, the tail of every instruction
  localparam mcycle_t FETCH = '{addr_src: ADDR_PC, data_bus_op: DATA_BUS_OP_READ,
                                data_bus_reg: REG_IR, idu_op: IDU_INC, alu_op: ALU_NOP,
                                alu_dst: REG_A, alu_src: REG_A, misc_op: MISC_NONE,
                                cond: COND_ALWAYS};

  logic [2:0] dst_code;
  logic [2:0] src_code;

  function automatic reg_sel_t reg_from_code(input logic [2:0] code);
    case (code)
      3'd0: return REG_B;
      3'd1: return REG_C;
      3'd2: return REG_D;
      3'd3: return REG_E;
      3'd4: return REG_H;
      3'd5: return REG_L;
      default: return REG_A;  // Code 6 is (HL), filtered by the caller
    endcase
  endfunction

  function automatic alu_op_t alu_from_code(input logic [2:0] code);
    case (code)
      3'd0: return ALU_ADD;
      3'd2: return ALU_SUB;
      3'd4: return ALU_AND;
      3'd5: return ALU_XOR;
      3'd6: return ALU_OR;
      3'd7: return ALU_CP;
      default: return ALU_NOP;  // ADC and SBC fall back to NOP
    endcase
  endfunction

  // Immediate byte from PC into a register
  function automatic mcycle_t imm_read(input reg_sel_t dst);
    mcycle_t m;
    m = FETCH;
    m.data_bus_reg = dst;
    return m;
  endfunction

  // Internal cycle with no bus traffic
  function automatic mcycle_t internal(input misc_op_t op);
    mcycle_t m;
    m = FETCH;
    m.addr_src = ADDR_NONE;
    m.data_bus_op = DATA_BUS_OP_ALU_ONLY;
    m.idu_op = IDU_NONE;
    m.misc_op = op;
    return m;
  endfunction

  assign dst_code = opcode[5:3];
  assign src_code = opcode[2:0];

  always_comb begin
    control_word.cycles = {`MAX_CYCLES_PER_INSTR{FETCH}};
    control_word.num_cycles = 3'd1;
    casez (opcode)
      8'h21: begin  // LD HL,d16
        control_word.cycles[0] = imm_read(REG_L);
        control_word.cycles[1] = imm_read(REG_H);
        control_word.num_cycles = 3'd3;
      end
      8'hc3: begin  // JP a16
        control_word.cycles[0] = imm_read(REG_Z_TMP);
        control_word.cycles[1] = imm_read(REG_W_TMP);
        control_word.cycles[2] = internal(MISC_JP_LOAD);
        control_word.num_cycles = 3'd4;
      end
      8'h18, 8'h20, 8'h28, 8'h30, 8'h38: begin
        // JR cc; an untaken branch skips straight to the last slot, which is also a fetch
        control_word.cycles[0] = imm_read(REG_Z_TMP);
        control_word.cycles[0].misc_op = MISC_COND_CHECK;
        if (opcode[5])
          control_word.cycles[0].cond = cond_t'(3'd1 + {1'b0, opcode[4:3]});
        control_word.cycles[1] = internal(MISC_JR_ADD);
        control_word.num_cycles = 3'd3;
      end
      8'h76: control_word.cycles[0] = internal(MISC_HALT);
      8'h77: begin  // LD (HL),A
        control_word.cycles[0] = internal(MISC_NONE);
        control_word.cycles[0].addr_src = ADDR_HL;
        control_word.cycles[0].data_bus_op = DATA_BUS_OP_WRITE;
        control_word.cycles[0].data_bus_reg = REG_A;
        control_word.num_cycles = 3'd2;
      end
      8'h7e: begin  // LD A,(HL)
        control_word.cycles[0] = imm_read(REG_A);
        control_word.cycles[0].addr_src = ADDR_HL;
        control_word.cycles[0].idu_op = IDU_NONE;
        control_word.num_cycles = 3'd2;
      end
      8'b00???110: begin  // LD r,d8
        if (dst_code != 3'd6) begin
          control_word.cycles[0] = imm_read(reg_from_code(dst_code));
          control_word.num_cycles = 3'd2;
        end
      end
      8'b00???10?: begin  // INC r, DEC r
        if (dst_code != 3'd6) begin
          control_word.cycles[0].alu_op = opcode[0] ? ALU_DEC : ALU_INC;
          control_word.cycles[0].alu_dst = reg_from_code(dst_code);
          control_word.cycles[0].alu_src = reg_from_code(dst_code);
        end
      end
      8'b01??????: begin  // LD r,r'
        if (dst_code != 3'd6 && src_code != 3'd6) begin
          control_word.cycles[0].alu_op = ALU_MOV;
          control_word.cycles[0].alu_dst = reg_from_code(dst_code);
          control_word.cycles[0].alu_src = reg_from_code(src_code);
        end
      end
      8'b10??????: begin  // ALU A,r
        if (src_code != 3'd6) begin
          control_word.cycles[0].alu_op = alu_from_code(dst_code);
          control_word.cycles[0].alu_src = reg_from_code(src_code);
        end
      end
      8'b11???110: begin  // ALU A,d8
        control_word.cycles[0] = imm_read(REG_Z_TMP);
        control_word.cycles[1].alu_op = alu_from_code(dst_code);
        control_word.cycles[1].alu_src = REG_Z_TMP;
        control_word.num_cycles = 3'd2;
      end
      default: control_word.num_cycles = 3'd1;  // Unknown opcodes run as NOP
    endcase
  end

endmodule

//--- verilog/mmu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module mmu
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  bus_req_t cpu_req,
  output byte_t    rdata,
  output bus_req_t cart_req,
  input  byte_t    cart_rdata
);

  localparam int WRAM_AW = $clog2(`WRAM_DEPTH);

  byte_t              wram [`WRAM_DEPTH];
  logic               in_wram;
  logic [WRAM_AW-1:0] wram_idx;
  logic               write_q;  // Strobe seen last cycle

  assign in_wram  = (cpu_req.addr >= addr_t'(`WRAM_BASE)) &&
                    (cpu_req.addr < addr_t'(`WRAM_BASE + `WRAM_DEPTH));
  assign wram_idx = cpu_req.addr[WRAM_AW-1:0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      write_q <= 1'b0;
    else
      write_q <= cpu_req.write;
  end

  // First edge with the strobe up is the T3 to T4 edge
  always_ff @(posedge clk) begin
    if (in_wram && cpu_req.write && !write_q)
      wram[wram_idx] <= cpu_req.wdata;
  end

  assign rdata = in_wram ? wram[wram_idx] : cart_rdata;

  always_comb begin
    cart_req       = cpu_req;
    cart_req.read  = cpu_req.read && !in_wram;
    cart_req.write = cpu_req.write && !in_wram;
  end

  a_cart_outside_wram: assert property (@(posedge clk) disable iff (reset)
    (cart_req.read || cart_req.write) |-> $stable(cart_req.addr) && !in_wram);

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_core
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output bus_req_t bus_req,
  input  byte_t    rdata,
  output logic     halted
);

  localparam cycle_count_t LAST_SLOT = cycle_count_t'(`MAX_CYCLES_PER_INSTR - 1);

  cpu_regs_t     regs;
  t_phase_t      t_phase;
  cycle_count_t  cycle_count;
  control_word_t control_word;
  mcycle_t       cur;
  byte_t         data_q;  // Read byte, sampled at the end of T3
  byte_t         alu_a;
  byte_t         alu_b;
  byte_t         alu_result;
  flags_t        alu_flags;
  logic          last_cycle;
  logic          cond_ok;

  function automatic byte_t get_reg(input cpu_regs_t r, input reg_sel_t sel);
    case (sel)
      REG_A: return r.a;
      REG_B: return r.b;
      REG_C: return r.c;
      REG_D: return r.d;
      REG_E: return r.e;
      REG_H: return r.h;
      REG_L: return r.l;
      REG_Z_TMP: return r.z;
      REG_W_TMP: return r.w;
      default: return r.ir;
    endcase
  endfunction

  function automatic cpu_regs_t put_reg(input cpu_regs_t r, input reg_sel_t sel,
                                        input byte_t val);
    cpu_regs_t n;
    n = r;
    case (sel)
      REG_A: n.a = val;
      REG_B: n.b = val;
      REG_C: n.c = val;
      REG_D: n.d = val;
      REG_E: n.e = val;
      REG_H: n.h = val;
      REG_L: n.l = val;
      REG_Z_TMP: n.z = val;
      REG_W_TMP: n.w = val;
      default: n.ir = val;
    endcase
    return n;
  endfunction

  function automatic addr_t get_addr(input cpu_regs_t r, input addr_src_t src);
    case (src)
      ADDR_HL: return {r.h, r.l};
      ADDR_WZ: return {r.w, r.z};
      default: return r.pc;
    endcase
  endfunction

  // Increment/decrement unit write-back to the address source
  function automatic cpu_regs_t put_addr(input cpu_regs_t r, input addr_src_t src,
                                         input addr_t val);
    cpu_regs_t n;
    n = r;
    case (src)
      ADDR_PC: n.pc = val;
      ADDR_HL: {n.h, n.l} = val;
      ADDR_WZ: {n.w, n.z} = val;
      default: n.pc = r.pc;
    endcase
    return n;
  endfunction

  instr_decoder u_instr_decoder (
    .opcode      (regs.ir),
    .control_word(control_word)
  );

  assign cur   = control_word.cycles[cycle_count];
  assign alu_a = get_reg(regs, cur.alu_dst);
  assign alu_b = get_reg(regs, cur.alu_src);

  alu u_alu (
    .op       (cur.alu_op),
    .a        (alu_a),
    .b        (alu_b),
    .flags_in (regs.flags),
    .result   (alu_result),
    .flags_out(alu_flags)
  );

  // Untaken JR jumps to the last slot, so that slot ends an instruction too
  assign last_cycle = (cycle_count == control_word.num_cycles - 3'd1) ||
                      (cycle_count == LAST_SLOT);

  always_comb begin
    case (cur.cond)
      COND_NZ: cond_ok = !regs.flags.z;
      COND_Z:  cond_ok = regs.flags.z;
      COND_NC: cond_ok = !regs.flags.c;
      COND_C:  cond_ok = regs.flags.c;
      default: cond_ok = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (t_phase == T3)
      data_q <= rdata;
  end

  always_ff @(posedge clk or posedge reset) begin
    cpu_regs_t nxt;
    if (reset) begin
      regs        <= '0;  // IR of 0x00 makes the first cycle a fetch
      regs.pc     <= `PC_RESET;
      regs.sp     <= `SP_RESET;
      t_phase     <= T1;
      cycle_count <= '0;
      bus_req     <= '0;
      halted      <= 1'b0;
    end else if (!halted) begin
      case (t_phase)
        T1: begin
          if (cur.addr_src != ADDR_NONE)
            bus_req.addr <= get_addr(regs, cur.addr_src);
          t_phase <= T2;
        end
        T2: begin
          bus_req.read  <= (cur.data_bus_op == DATA_BUS_OP_READ);
          bus_req.write <= (cur.data_bus_op == DATA_BUS_OP_WRITE);
          bus_req.wdata <= get_reg(regs, cur.data_bus_reg);
          t_phase       <= T3;
        end
        T3: t_phase <= T4;
        T4: begin
          nxt = regs;
          if (cur.data_bus_op == DATA_BUS_OP_READ)
            nxt = put_reg(nxt, cur.data_bus_reg, data_q);
          if (cur.alu_op != ALU_NOP) begin
            nxt = put_reg(nxt, cur.alu_dst, alu_result);
            nxt.flags = alu_flags;
          end
          if (cur.idu_op == IDU_INC)
            nxt = put_addr(nxt, cur.addr_src, get_addr(regs, cur.addr_src) + 16'd1);
          case (cur.misc_op)
            MISC_JP_LOAD: nxt.pc = {regs.w, regs.z};
            MISC_JR_ADD:  nxt.pc = regs.pc + {{8{regs.z[7]}}, regs.z};  // Signed offset
            MISC_HALT:    halted <= 1'b1;
            default:      nxt.pc = nxt.pc;
          endcase
          regs <= nxt;

          bus_req.read  <= 1'b0;
          bus_req.write <= 1'b0;

          if (cur.misc_op == MISC_COND_CHECK && !cond_ok)
            cycle_count <= LAST_SLOT;
          else if (last_cycle)
            cycle_count <= '0;
          else
            cycle_count <= cycle_count + 3'd1;
          t_phase <= T1;
        end
        default: t_phase <= T1;
      endcase
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (reset)
    !(bus_req.read && bus_req.write));

  // Strobes drop in T4, so the next cycle opens quiet
  a_quiet_t1: assert property (@(posedge clk) disable iff (reset)
    (t_phase == T1) |-> !(bus_req.read || bus_req.write));

endmodule

//--- verilog/gb_soc.sv
`timescale 1ns/100ps

module gb_soc
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output bus_req_t cart_req,
  input  byte_t    cart_rdata,
  output logic     halted
);

  bus_req_t cpu_req;
  byte_t    cpu_rdata;

  cpu_core u_cpu_core (
    .clk    (clk),
    .reset  (reset),
    .bus_req(cpu_req),
    .rdata  (cpu_rdata),
    .halted (halted)
  );

  mmu u_mmu (
    .clk       (clk),
    .reset     (reset),
    .cpu_req   (cpu_req),
    .rdata     (cpu_rdata),
    .cart_req  (cart_req),
    .cart_rdata(cart_rdata)
  );

endmodule

//--- test/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Galois LFSR, shifting right with the feedback taps in the top bits
function automatic logic [31:0] galois_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic int take_bits(input int n);
  int v;
  int i;
  v = 0;
  for (i = 0; i < n; i++) begin
    v = (v << 1) | int'(lfsr[0]);
    lfsr = galois_next(lfsr);
  end
  return v;
endfunction

function automatic bit in_wram(input addr_t addr);
  return (addr >= `WRAM_BASE) && (addr < `WRAM_BASE + `WRAM_DEPTH);
endfunction

// Register code from B, C, D, E or A; H and L stay reserved for the pointer
function automatic logic [2:0] pick_reg();
  int v;
  v = take_bits(3);
  return (v < 4) ? v[2:0] : 3'd7;
endfunction

function automatic logic [2:0] pick_alu();
  int v;
  v = take_bits(3);
  if (v == 1 || v == 3)
    v = v - 1;  // No ADC or SBC
  return v[2:0];
endfunction

function automatic byte_t pick_jr();
  case (take_bits(3) % 5)
    0: return 8'h18;
    1: return 8'h20;
    2: return 8'h28;
    3: return 8'h30;
    default: return 8'h38;
  endcase
endfunction

function automatic void emit(input byte_t b);
  cart_mem[gen_pos] = b;
  gen_pos++;
endfunction

// Random program at 0x0000; jumps only go forward, never nested
task automatic gen_program();
  int         count;
  int         kind;
  int         pend;       // Instructions still to cover by the open jump
  int         was_pend;
  int         patch_at;
  bit         patch_jp;
  addr_t      hl;
  logic [2:0] r;
  logic [2:0] o;
  gen_pos = 0;
  count = 0;
  pend = 0;
  patch_at = 0;
  patch_jp = 1'b0;
  hl = 16'h0000;  // Registers clear on reset
  while (count < PROG_INSTRS || pend != 0) begin
    kind = take_bits(4);
    was_pend = pend;
    if (pend != 0 && (kind == 3 || kind >= 13))
      kind = 5;
    if (kind == 4 && in_wram(hl) && !wram_written[hl[7:0]])
      kind = 5;  // Never read work RAM that holds no known value
    case (kind)
      0: emit(8'h00);
      1, 2: begin
        r = pick_reg();
        emit({2'b00, r, 3'b110});
        emit(byte_t'(take_bits(8)));
      end
      3: begin
        if (take_bits(1) != 0)
          hl = 16'hc000 | addr_t'(take_bits(8));
        else
          hl = 16'h4000 | addr_t'(take_bits(14));
        emit(8'h21);
        emit(hl[7:0]);
        emit(hl[15:8]);
      end
      4: emit(8'h7e);
      7: begin
        r = pick_reg();
        emit({2'b01, r, pick_reg()});
      end
      8, 9: begin
        o = pick_alu();
        r = pick_reg();
        emit({2'b10, o, r});
      end
      10, 11: begin
        o = pick_alu();
        emit({2'b11, o, 3'b110});
        emit(byte_t'(take_bits(8)));
      end
      12: begin
        r = pick_reg();
        emit({2'b00, r, 2'b10, take_bits(1) == 1});
      end
      13: begin
        emit(8'hc3);
        patch_at = gen_pos;
        emit(8'h00);
        emit(8'h00);
        patch_jp = 1'b1;
        pend = 1 + take_bits(1);
      end
      14, 15: begin
        emit(pick_jr());
        patch_at = gen_pos;
        emit(8'h00);
        patch_jp = 1'b0;
        pend = 1 + take_bits(2) % 3;
      end
      default: begin  // LD (HL),A
        emit(8'h77);
        if (was_pend == 0 && in_wram(hl))
          wram_written[hl[7:0]] = 1'b1;
      end
    endcase
    count++;
    if (was_pend != 0) begin
      pend--;
      if (pend == 0 && patch_jp) begin
        cart_mem[patch_at] = byte_t'(gen_pos);
        cart_mem[patch_at + 1] = byte_t'(gen_pos >> 8);
      end else if (pend == 0) begin
        cart_mem[patch_at] = byte_t'(gen_pos - patch_at - 1);
      end
    end
  end
  emit(8'h76);
endtask

function automatic byte_t read_ref(input addr_t addr);
  if (in_wram(addr))
    return wram_model[addr[7:0]];
  exp_reads.push_back(addr);
  return cart_mem[addr[14:0]];
endfunction

function automatic void store_ref(input addr_t addr, input byte_t data);
  if (in_wram(addr))
    wram_model[addr[7:0]] = data;
  else
    exp_writes.push_back({addr, data});
endfunction

// kind: ALU field of the opcode, 8 for INC, 9 for DEC
task automatic alu_ref(input int kind, input byte_t x, input byte_t y,
                       inout flags_t fl, output byte_t res);
  logic [8:0] wide;
  res = x;
  case (kind)
    0: begin
      wide = {1'b0, x} + {1'b0, y};
      res = wide[7:0];
      fl.n = 1'b0;
      fl.h = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
      fl.c = wide[8];
    end
    2, 7: begin
      res = x - y;
      fl.n = 1'b1;
      fl.h = x[3:0] < y[3:0];
      fl.c = x < y;
    end
    4: begin
      res = x & y;
      fl.n = 1'b0;
      fl.h = 1'b1;
      fl.c = 1'b0;
    end
    5, 6: begin
      res = (kind == 5) ? (x ^ y) : (x | y);
      fl.n = 1'b0;
      fl.h = 1'b0;
      fl.c = 1'b0;
    end
    8: begin
      res = x + 8'd1;
      fl.n = 1'b0;
      fl.h = (x[3:0] == 4'hf);
    end
    default: begin
      res = x - 8'd1;
      fl.n = 1'b1;
      fl.h = (x[3:0] == 4'h0);
    end
  endcase
  fl.z = (res == 8'h00);
  if (kind == 7)
    res = x;  // CP keeps A
endtask

// Instruction-level run; the final fetch of each instruction is one machine cycle
task automatic run_model(output int mcycles);
  byte_t  rf [0:7];  // Indexed by opcode register code, A at 7
  flags_t fl;
  addr_t  pc;
  addr_t  hl;
  byte_t  op;
  byte_t  imm;
  bit     done;
  bit     taken;
  int     steps;
  int     i;
  exp_reads.delete();
  exp_writes.delete();
  for (i = 0; i < 8; i++)
    rf[i] = 8'h00;
  fl = '0;
  done = 1'b0;
  steps = 0;
  mcycles = 1;
  op = read_ref(`PC_RESET);
  pc = `PC_RESET + 16'd1;
  while (!done && steps < 400) begin
    steps++;
    hl = {rf[4], rf[5]};
    if (op == 8'h76) begin
      done = 1'b1;
      mcycles += 1;
    end else begin
      if (op == 8'h21) begin
        rf[5] = read_ref(pc);
        rf[4] = read_ref(pc + 16'd1);
        pc += 16'd2;
        mcycles += 3;
      end else if (op == 8'hc3) begin
        imm = read_ref(pc);
        pc = {read_ref(pc + 16'd1), imm};
        mcycles += 4;
      end else if (op == 8'h18 || op == 8'h20 || op == 8'h28 || op == 8'h30 ||
                   op == 8'h38) begin
        imm = read_ref(pc);
        pc += 16'd1;
        case (op)
          8'h20: taken = !fl.z;
          8'h28: taken = fl.z;
          8'h30: taken = !fl.c;
          8'h38: taken = fl.c;
          default: taken = 1'b1;
        endcase
        if (taken)
          pc = pc + {{8{imm[7]}}, imm};
        mcycles += taken ? 3 : 2;
      end else if (op == 8'h77) begin
        store_ref(hl, rf[7]);
        mcycles += 2;
      end else if (op == 8'h7e) begin
        rf[7] = read_ref(hl);
        mcycles += 2;
      end else if (op[7:6] == 2'b00 && op[2:0] == 3'b110) begin
        rf[op[5:3]] = read_ref(pc);
        pc += 16'd1;
        mcycles += 2;
      end else if (op[7:6] == 2'b00 && op[2:1] == 2'b10) begin
        alu_ref(op[0] ? 9 : 8, rf[op[5:3]], 8'h00, fl, rf[op[5:3]]);
        mcycles += 1;
      end else if (op[7:6] == 2'b01) begin
        rf[op[5:3]] = rf[op[2:0]];
        mcycles += 1;
      end else if (op[7:6] == 2'b10) begin
        alu_ref(int'(op[5:3]), rf[7], rf[op[2:0]], fl, rf[7]);
        mcycles += 1;
      end else if (op[7:6] == 2'b11 && op[2:0] == 3'b110) begin
        imm = read_ref(pc);
        pc += 16'd1;
        alu_ref(int'(op[5:3]), rf[7], imm, fl, rf[7]);
        mcycles += 2;
      end else begin
        mcycles += 1;  // NOP
      end
      op = read_ref(pc);
      pc += 16'd1;
    end
  end
  check_cond(done, "reference model never reached HALT");
endtask

`endif

//--- test/tb_gb_soc.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module tb_gb_soc
  import cpu_pkg::*;
();

  localparam int NUM_PROGS    = 8;
  localparam int PROG_INSTRS  = 30;
  localparam int CLK_NS       = 20;
  localparam int RESET_CYCLES = 4;
  localparam int WATCHDOG_NS  = NUM_PROGS * (PROG_INSTRS + 1) * `MAX_CYCLES_PER_INSTR * 4 *
                                CLK_NS + 20000;

  logic     clk;
  logic     reset;
  bus_req_t cart_req;
  byte_t    cart_rdata;
  logic     halted;

  byte_t        cart_mem [0:32767];
  byte_t        wram_model [0:255];
  bit           wram_written [0:255];
  addr_t        exp_reads [$];
  logic [23:0]  exp_writes [$];  // {addr, data}
  logic [23:0]  got_writes [$];
  logic [31:0]  lfsr;
  int           gen_pos;

  int errors;
  int checks;
  int edge_count;  // Rising clock edges since reset release
  int read_idx;
  int halt_edge;
  bit halt_seen;
  bit prev_read;
  bit prev_write;
  bit in_reset;

  `include "cpu_model.svh"

  gb_soc u_gb_soc (
    .clk       (clk),
    .reset     (reset),
    .cart_req  (cart_req),
    .cart_rdata(cart_rdata),
    .halted    (halted)
  );

  // Cartridge answers in the same cycle
  assign cart_rdata = cart_mem[cart_req.addr[14:0]];

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Failure: %s", what);
    end
  endtask

  function automatic byte_t fill_byte(input int a);
    return byte_t'(a) ^ byte_t'(a >> 7) ^ 8'h5c;
  endfunction

  always @(posedge clk or posedge reset) begin
    if (reset)
      edge_count <= 0;
    else
      edge_count <= edge_count + 1;
  end

  always @(negedge clk) begin
    if (reset) begin
      if (in_reset)  // Skip the edge where reset was just raised
        check_cond(!cart_req.read && !cart_req.write && !halted,
                   "strobe or halted high during reset");
      in_reset = 1'b1;
      prev_read = 1'b0;
      prev_write = 1'b0;
    end else begin
      in_reset = 1'b0;
      if (cart_req.read || cart_req.write)
        check_cond(!in_wram(cart_req.addr), "work RAM access seen on the cartridge port");
      if (cart_req.read && !prev_read) begin
        if (read_idx == 0)
          check_value("first_fetch", `PC_RESET, cart_req.addr);
        if (read_idx < exp_reads.size())
          check_value("cart_read_addr", exp_reads[read_idx], cart_req.addr);
        else
          check_cond(1'b0, "more cartridge reads than the model predicts");
        read_idx++;
      end
      if (cart_req.write && !prev_write)
        got_writes.push_back({cart_req.addr, cart_req.wdata});
      if (halted && !halt_seen) begin
        halt_seen = 1'b1;
        halt_edge = edge_count;
      end
      if (halt_seen)
        check_cond(!cart_req.read && !cart_req.write, "bus strobe after halt");
      prev_read = cart_req.read;
      prev_write = cart_req.write;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: programs did not finish within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int prog;
    int i;
    int mcycles;
    reset = 1'b1;
    errors = 0;
    checks = 0;
    read_idx = 0;
    halt_seen = 1'b0;
    halt_edge = 0;
    in_reset = 1'b0;
    lfsr = 32'h3a20;
    for (i = 0; i < 32768; i++)
      cart_mem[i] = fill_byte(i);
    for (i = 0; i < 256; i++)
      wram_written[i] = 1'b0;
    for (prog = 0; prog < NUM_PROGS; prog++) begin
      gen_program();
      run_model(mcycles);
      @(negedge clk);
      reset = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      read_idx = 0;
      halt_seen = 1'b0;
      got_writes.delete();
      reset = 1'b0;
      while (!halt_seen)
        @(negedge clk);
      repeat (8) @(negedge clk);  // Bus must stay quiet after halt
      check_value("halt_cycles", 4 * mcycles, halt_edge);
      check_value("read_count", exp_reads.size(), read_idx);
      check_value("write_count", exp_writes.size(), got_writes.size());
      for (i = 0; i < exp_writes.size() && i < got_writes.size(); i++)
        check_value("cart_write", exp_writes[i], got_writes[i]);
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+verilog
+incdir+test
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/instr_decoder.sv
verilog/mmu.sv
verilog/cpu_core.sv
verilog/gb_soc.sv
test/tb_gb_soc.sv
